/* hdl/boot_pkg.sv */
// Boot subsystem definitions
package boot_pkg;

   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int MEM_WORDS   = 256;
   localparam int MEM_AW      = 8;
   localparam int MEM_LATENCY = 2;
   localparam int WAIT_W      = $clog2(MEM_LATENCY + 1);

   localparam logic [7:0] CORE_ID = 8'h01;

   localparam logic [1:0] HOST_REG_CORE_ID = 2'd0;
   localparam logic [1:0] HOST_REG_FREEZE  = 2'd1;
   localparam logic [1:0] HOST_REG_FINISH  = 2'd2;
   localparam logic [1:0] HOST_REG_SCRATCH = 2'd3;

   // Bus owner, in boot order
   localparam logic [1:0] GNT_CFG = 2'd0;
   localparam logic [1:0] GNT_NBF = 2'd1;
   localparam logic [1:0] GNT_EXT = 2'd2;

   typedef struct packed {
      logic                     region;
      logic [ADDR_W-MEM_AW-4:0] upper;
      logic [MEM_AW-1:0]        index;
      logic [1:0]               byte_sel;
   } mem_addr_t;

   typedef struct packed {
      logic              region;
      logic [ADDR_W-6:0] unused;
      logic [1:0]        sel;
      logic [1:0]        byte_sel;
   } host_addr_t;

   // Region 1 selects the host registers
   typedef union packed {
      mem_addr_t  mem;
      host_addr_t host;
   } bus_addr_u;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } cfg_entry_t;

   function automatic logic [ADDR_W-1:0] host_addr(logic [1:0] sel);
      bus_addr_u a;
      a             = '0;
      a.host.region = 1'b1;
      a.host.sel    = sel;
      return a;
   endfunction

   localparam int CFG_COUNT = 3;
   localparam int CFG_IDX_W = $clog2(CFG_COUNT);

   // Entry 0 in the low slot, freeze release goes out last
   localparam cfg_entry_t [CFG_COUNT-1:0] CFG_TABLE = {
      cfg_entry_t'{addr: host_addr(HOST_REG_FREEZE),  data: '0},
      cfg_entry_t'{addr: host_addr(HOST_REG_SCRATCH), data: '0},
      cfg_entry_t'{addr: host_addr(HOST_REG_CORE_ID), data: DATA_W'(CORE_ID)}
   };

endpackage

/* hdl/cfg_loader.sv */
// Configuration table loader
`timescale 1ns/100ps

module cfg_loader import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   output logic              cfg_psel_o,
   output logic              cfg_penable_o,
   output logic              cfg_pwrite_o,
   output logic [ADDR_W-1:0] cfg_paddr_o,
   output logic [DATA_W-1:0] cfg_pwdata_o,
   input  logic              cfg_pready_i,
   input  logic              cfg_pslverr_i,
   output logic              cfg_done_o
);

   logic [CFG_IDX_W-1:0] idx_q;

   assign cfg_pwrite_o = 1'b1;
   assign cfg_paddr_o  = CFG_TABLE[idx_q].addr;
   assign cfg_pwdata_o = CFG_TABLE[idx_q].data;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cfg_psel_o    <= 1'b0;
         cfg_penable_o <= 1'b0;
         cfg_done_o    <= 1'b0;
         idx_q         <= '0;
      end
      else if (!cfg_done_o)
      begin
         if (!cfg_psel_o)
            cfg_psel_o <= 1'b1;
         else if (!cfg_penable_o)
            cfg_penable_o <= 1'b1;
         else if (cfg_pready_i)
         begin
            // Back to setup; a refused write goes out again
            cfg_penable_o <= 1'b0;
            if (!cfg_pslverr_i)
            begin
               if (idx_q == CFG_IDX_W'(CFG_COUNT - 1))
               begin
                  cfg_psel_o <= 1'b0;
                  cfg_done_o <= 1'b1;
               end
               else
                  idx_q <= idx_q + 1'b1;
            end
         end
      end
   end

endmodule

/* hdl/nbf_loader.sv */
// Program stream loader
`timescale 1ns/100ps

module nbf_loader import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              start_i,
   input  logic              nbf_valid_i,
   output logic              nbf_ready_o,
   input  logic [ADDR_W-1:0] nbf_addr_i,
   input  logic [DATA_W-1:0] nbf_data_i,
   input  logic              nbf_last_i,
   output logic              nbf_psel_o,
   output logic              nbf_penable_o,
   output logic              nbf_pwrite_o,
   output logic [ADDR_W-1:0] nbf_paddr_o,
   output logic [DATA_W-1:0] nbf_pwdata_o,
   input  logic              nbf_pready_i,
   input  logic              nbf_pslverr_i,
   output logic              nbf_done_o
);

   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] data_q;
   logic              last_q;

   // Ready only while no write is in flight
   assign nbf_ready_o  = start_i & ~nbf_done_o & ~nbf_psel_o;
   assign nbf_pwrite_o = 1'b1;
   assign nbf_paddr_o  = addr_q;
   assign nbf_pwdata_o = data_q;

   always_ff @(posedge clk_i)
   begin
      if (nbf_ready_o && nbf_valid_i)
      begin
         addr_q <= nbf_addr_i;
         data_q <= nbf_data_i;
         last_q <= nbf_last_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         nbf_psel_o    <= 1'b0;
         nbf_penable_o <= 1'b0;
         nbf_done_o    <= 1'b0;
      end
      else if (nbf_ready_o && nbf_valid_i)
         nbf_psel_o <= 1'b1;
      else if (nbf_psel_o && !nbf_penable_o)
         nbf_penable_o <= 1'b1;
      else if (nbf_penable_o && nbf_pready_i)
      begin
         nbf_penable_o <= 1'b0;
         if (!nbf_pslverr_i)
         begin
            nbf_psel_o <= 1'b0;
            nbf_done_o <= last_q;
         end
      end
   end

endmodule

/* hdl/load_arbiter.sv */
// Fixed order bus arbiter
`timescale 1ns/100ps

module load_arbiter import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              cfg_done_i,
   input  logic              nbf_done_i,
   input  logic              cfg_psel_i,
   input  logic              cfg_penable_i,
   input  logic              cfg_pwrite_i,
   input  logic [ADDR_W-1:0] cfg_paddr_i,
   input  logic [DATA_W-1:0] cfg_pwdata_i,
   output logic              cfg_pready_o,
   output logic              cfg_pslverr_o,
   input  logic              nbf_psel_i,
   input  logic              nbf_penable_i,
   input  logic              nbf_pwrite_i,
   input  logic [ADDR_W-1:0] nbf_paddr_i,
   input  logic [DATA_W-1:0] nbf_pwdata_i,
   output logic              nbf_pready_o,
   output logic              nbf_pslverr_o,
   input  logic              ext_psel_i,
   input  logic              ext_penable_i,
   input  logic              ext_pwrite_i,
   input  logic [ADDR_W-1:0] ext_paddr_i,
   input  logic [DATA_W-1:0] ext_pwdata_i,
   output logic [DATA_W-1:0] ext_prdata_o,
   output logic              ext_pready_o,
   output logic              ext_pslverr_o,
   output logic              bus_psel_o,
   output logic              bus_penable_o,
   output logic              bus_pwrite_o,
   output logic [ADDR_W-1:0] bus_paddr_o,
   output logic [DATA_W-1:0] bus_pwdata_o,
   input  logic [DATA_W-1:0] bus_prdata_i,
   input  logic              bus_pready_i,
   input  logic              bus_pslverr_i
);

   logic [1:0] grant_q;

   // Grant moves only between transfers
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         grant_q <= GNT_CFG;
      else if (!bus_psel_o)
         grant_q <= !cfg_done_i ? GNT_CFG : (!nbf_done_i ? GNT_NBF : GNT_EXT);
   end

   always_comb
   begin
      case (grant_q)
         GNT_CFG:
         begin
            bus_psel_o    = cfg_psel_i;
            bus_penable_o = cfg_penable_i;
            bus_pwrite_o  = cfg_pwrite_i;
            bus_paddr_o   = cfg_paddr_i;
            bus_pwdata_o  = cfg_pwdata_i;
         end
         GNT_NBF:
         begin
            bus_psel_o    = nbf_psel_i;
            bus_penable_o = nbf_penable_i;
            bus_pwrite_o  = nbf_pwrite_i;
            bus_paddr_o   = nbf_paddr_i;
            bus_pwdata_o  = nbf_pwdata_i;
         end
         default:
         begin
            bus_psel_o    = ext_psel_i;
            bus_penable_o = ext_penable_i;
            bus_pwrite_o  = ext_pwrite_i;
            bus_paddr_o   = ext_paddr_i;
            bus_pwdata_o  = ext_pwdata_i;
         end
      endcase
   end

   assign cfg_pready_o  = (grant_q == GNT_CFG) & bus_pready_i;
   assign cfg_pslverr_o = (grant_q == GNT_CFG) & bus_pslverr_i;
   assign nbf_pready_o  = (grant_q == GNT_NBF) & bus_pready_i;
   assign nbf_pslverr_o = (grant_q == GNT_NBF) & bus_pslverr_i;
   assign ext_pready_o  = (grant_q == GNT_EXT) & bus_pready_i;
   assign ext_pslverr_o = (grant_q == GNT_EXT) & bus_pslverr_i;
   assign ext_prdata_o  = (grant_q == GNT_EXT) ? bus_prdata_i : '0;

endmodule

/* hdl/periph_decoder.sv */
// Peripheral address decoder
`timescale 1ns/100ps

module periph_decoder import boot_pkg::*;
(
   input  logic              bus_psel_i,
   input  logic              bus_penable_i,
   input  logic              bus_pwrite_i,
   input  logic [ADDR_W-1:0] bus_paddr_i,
   input  logic [DATA_W-1:0] bus_pwdata_i,
   output logic [DATA_W-1:0] bus_prdata_o,
   output logic              bus_pready_o,
   output logic              bus_pslverr_o,
   output logic              mem_psel_o,
   output logic              host_psel_o,
   output logic              penable_o,
   output logic              pwrite_o,
   output logic [ADDR_W-1:0] paddr_o,
   output logic [DATA_W-1:0] pwdata_o,
   input  logic [DATA_W-1:0] mem_prdata_i,
   input  logic              mem_pready_i,
   input  logic [DATA_W-1:0] host_prdata_i,
   input  logic              host_pready_i
);

   bus_addr_u addr;
   logic      is_host;
   logic      is_mem;
   logic      err_sel;

   assign addr    = bus_paddr_i;
   assign is_host = addr.host.region;
   assign is_mem  = ~addr.mem.region & (addr.mem.upper == '0);
   assign err_sel = bus_psel_i & ~is_host & ~is_mem;

   assign mem_psel_o  = bus_psel_i & is_mem;
   assign host_psel_o = bus_psel_i & is_host;
   assign penable_o   = bus_penable_i;
   assign pwrite_o    = bus_pwrite_i;
   assign paddr_o     = bus_paddr_i;
   assign pwdata_o    = bus_pwdata_i;

   // Unmapped memory space is refused in the first access cycle
   assign bus_pslverr_o = err_sel & bus_penable_i;
   assign bus_pready_o  = is_host ? host_pready_i :
                          is_mem  ? mem_pready_i  : bus_pslverr_o;
   assign bus_prdata_o  = is_host ? host_prdata_i :
                          is_mem  ? mem_prdata_i  : '0;

endmodule

/* hdl/data_mem.sv */
// Word memory with wait states
`timescale 1ns/100ps

module data_mem import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              mem_psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [ADDR_W-1:0] paddr_i,
   input  logic [DATA_W-1:0] pwdata_i,
   output logic [DATA_W-1:0] prdata_o,
   output logic              pready_o
);

   logic [DATA_W-1:0] mem [MEM_WORDS];
   logic [WAIT_W-1:0] wait_q;
   bus_addr_u         addr;
   logic              access;

   assign addr     = paddr_i;
   assign access   = mem_psel_i & penable_i;
   assign pready_o = access & (wait_q == WAIT_W'(MEM_LATENCY));
   assign prdata_o = mem[addr.mem.index];

   // Counts access cycles until the last wait state
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         wait_q <= '0;
      else if (access && !pready_o)
         wait_q <= wait_q + 1'b1;
      else
         wait_q <= '0;
   end

   always_ff @(posedge clk_i)
   begin
      if (pready_o && pwrite_i)
         mem[addr.mem.index] <= pwdata_i;
   end

endmodule

/* hdl/host_regs.sv */
// Host control registers
`timescale 1ns/100ps

module host_regs import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              host_psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [ADDR_W-1:0] paddr_i,
   input  logic [DATA_W-1:0] pwdata_i,
   output logic [DATA_W-1:0] prdata_o,
   output logic              pready_o,
   output logic              freeze_o,
   output logic              finish_o
);

   bus_addr_u  addr;
   logic [7:0] core_id_q;
   logic [7:0] scratch_q;
   logic       wr_en;

   assign addr     = paddr_i;
   assign pready_o = host_psel_i & penable_i;
   assign wr_en    = pready_o & pwrite_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         core_id_q <= '0;
         scratch_q <= '0;
         freeze_o  <= 1'b1;
         finish_o  <= 1'b0;
      end
      else if (wr_en)
      begin
         case (addr.host.sel)
            HOST_REG_CORE_ID: core_id_q <= pwdata_i[7:0];
            HOST_REG_FREEZE:  freeze_o  <= pwdata_i[0];
            HOST_REG_FINISH:
            begin
               // Sticky until reset, exit code lands in scratch
               finish_o  <= 1'b1;
               scratch_q <= pwdata_i[7:0];
            end
            default:          scratch_q <= pwdata_i[7:0];
         endcase
      end
   end

   always_comb
   begin
      prdata_o = '0;
      case (addr.host.sel)
         HOST_REG_CORE_ID: prdata_o[7:0] = core_id_q;
         HOST_REG_FREEZE:  prdata_o[0]   = freeze_o;
         HOST_REG_FINISH:  prdata_o[0]   = finish_o;
         default:          prdata_o[7:0] = scratch_q;
      endcase
   end

endmodule

/* hdl/boot_mem_sys.sv */
// Boot and memory subsystem
`timescale 1ns/100ps

module boot_mem_sys import boot_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              nbf_valid_i,
   output logic              nbf_ready_o,
   input  logic [ADDR_W-1:0] nbf_addr_i,
   input  logic [DATA_W-1:0] nbf_data_i,
   input  logic              nbf_last_i,
   input  logic              ext_psel_i,
   input  logic              ext_penable_i,
   input  logic              ext_pwrite_i,
   input  logic [ADDR_W-1:0] ext_paddr_i,
   input  logic [DATA_W-1:0] ext_pwdata_i,
   output logic [DATA_W-1:0] ext_prdata_o,
   output logic              ext_pready_o,
   output logic              ext_pslverr_o,
   output logic              freeze_o,
   output logic              finish_o
);

   logic              cfg_psel, cfg_penable, cfg_pwrite, cfg_pready, cfg_pslverr;
   logic [ADDR_W-1:0] cfg_paddr;
   logic [DATA_W-1:0] cfg_pwdata;
   logic              cfg_done;
   logic              nbf_psel, nbf_penable, nbf_pwrite, nbf_pready, nbf_pslverr;
   logic [ADDR_W-1:0] nbf_paddr;
   logic [DATA_W-1:0] nbf_pwdata;
   logic              nbf_done;
   logic              bus_psel, bus_penable, bus_pwrite, bus_pready, bus_pslverr;
   logic [ADDR_W-1:0] bus_paddr;
   logic [DATA_W-1:0] bus_pwdata, bus_prdata;
   logic              mem_psel, host_psel, per_penable, per_pwrite;
   logic [ADDR_W-1:0] per_paddr;
   logic [DATA_W-1:0] per_pwdata, mem_prdata, host_prdata;
   logic              mem_pready, host_pready;

   cfg_loader u_cfg_loader (
      .clk_i(clk_i), .reset_i(reset_i),
      .cfg_psel_o(cfg_psel), .cfg_penable_o(cfg_penable), .cfg_pwrite_o(cfg_pwrite),
      .cfg_paddr_o(cfg_paddr), .cfg_pwdata_o(cfg_pwdata),
      .cfg_pready_i(cfg_pready), .cfg_pslverr_i(cfg_pslverr), .cfg_done_o(cfg_done)
   );

   // Program loading waits for the configuration to finish
   nbf_loader u_nbf_loader (
      .clk_i(clk_i), .reset_i(reset_i), .start_i(cfg_done),
      .nbf_valid_i(nbf_valid_i), .nbf_ready_o(nbf_ready_o), .nbf_addr_i(nbf_addr_i),
      .nbf_data_i(nbf_data_i), .nbf_last_i(nbf_last_i),
      .nbf_psel_o(nbf_psel), .nbf_penable_o(nbf_penable), .nbf_pwrite_o(nbf_pwrite),
      .nbf_paddr_o(nbf_paddr), .nbf_pwdata_o(nbf_pwdata),
      .nbf_pready_i(nbf_pready), .nbf_pslverr_i(nbf_pslverr), .nbf_done_o(nbf_done)
   );

   load_arbiter u_load_arbiter (
      .clk_i(clk_i), .reset_i(reset_i), .cfg_done_i(cfg_done), .nbf_done_i(nbf_done),
      .cfg_psel_i(cfg_psel), .cfg_penable_i(cfg_penable), .cfg_pwrite_i(cfg_pwrite),
      .cfg_paddr_i(cfg_paddr), .cfg_pwdata_i(cfg_pwdata),
      .cfg_pready_o(cfg_pready), .cfg_pslverr_o(cfg_pslverr),
      .nbf_psel_i(nbf_psel), .nbf_penable_i(nbf_penable), .nbf_pwrite_i(nbf_pwrite),
      .nbf_paddr_i(nbf_paddr), .nbf_pwdata_i(nbf_pwdata),
      .nbf_pready_o(nbf_pready), .nbf_pslverr_o(nbf_pslverr),
      .ext_psel_i(ext_psel_i), .ext_penable_i(ext_penable_i), .ext_pwrite_i(ext_pwrite_i),
      .ext_paddr_i(ext_paddr_i), .ext_pwdata_i(ext_pwdata_i), .ext_prdata_o(ext_prdata_o),
      .ext_pready_o(ext_pready_o), .ext_pslverr_o(ext_pslverr_o),
      .bus_psel_o(bus_psel), .bus_penable_o(bus_penable), .bus_pwrite_o(bus_pwrite),
      .bus_paddr_o(bus_paddr), .bus_pwdata_o(bus_pwdata), .bus_prdata_i(bus_prdata),
      .bus_pready_i(bus_pready), .bus_pslverr_i(bus_pslverr)
   );

   periph_decoder u_periph_decoder (
      .bus_psel_i(bus_psel), .bus_penable_i(bus_penable), .bus_pwrite_i(bus_pwrite),
      .bus_paddr_i(bus_paddr), .bus_pwdata_i(bus_pwdata), .bus_prdata_o(bus_prdata),
      .bus_pready_o(bus_pready), .bus_pslverr_o(bus_pslverr),
      .mem_psel_o(mem_psel), .host_psel_o(host_psel), .penable_o(per_penable),
      .pwrite_o(per_pwrite), .paddr_o(per_paddr), .pwdata_o(per_pwdata),
      .mem_prdata_i(mem_prdata), .mem_pready_i(mem_pready),
      .host_prdata_i(host_prdata), .host_pready_i(host_pready)
   );

   data_mem u_data_mem (
      .clk_i(clk_i), .reset_i(reset_i), .mem_psel_i(mem_psel), .penable_i(per_penable),
      .pwrite_i(per_pwrite), .paddr_i(per_paddr), .pwdata_i(per_pwdata),
      .prdata_o(mem_prdata), .pready_o(mem_pready)
   );

   host_regs u_host_regs (
      .clk_i(clk_i), .reset_i(reset_i), .host_psel_i(host_psel), .penable_i(per_penable),
      .pwrite_i(per_pwrite), .paddr_i(per_paddr), .pwdata_i(per_pwdata),
      .prdata_o(host_prdata), .pready_o(host_pready),
      .freeze_o(freeze_o), .finish_o(finish_o)
   );

endmodule

/* verif/boot_mem_sys_sva.sv */
// Shared bus protocol checks
`timescale 1ns/100ps

module boot_mem_sys_sva import boot_pkg::*;
(
   input logic              clk_i,
   input logic              reset_i,
   input logic              psel_i,
   input logic              penable_i,
   input logic              pready_i,
   input logic [ADDR_W-1:0] paddr_i,
   input logic [DATA_W-1:0] pwdata_i
);

   penable_needs_psel: assert property (@(posedge clk_i) disable iff (reset_i)
      penable_i |-> psel_i)
      else $error("Shared bus has penable without psel");

   // Address and write data hold until the slave answers
   request_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      psel_i && !pready_i |=> $stable(paddr_i) && $stable(pwdata_i))
      else $error("Shared bus paddr or pwdata changed before pready");

   setup_then_access: assert property (@(posedge clk_i) disable iff (reset_i)
      psel_i && !penable_i |=> penable_i)
      else $error("Shared bus setup cycle not followed by penable");

endmodule

bind boot_mem_sys boot_mem_sys_sva u_bus_sva (
   .clk_i(clk_i),
   .reset_i(reset_i),
   .psel_i(bus_psel),
   .penable_i(bus_penable),
   .pready_i(bus_pready),
   .paddr_i(bus_paddr),
   .pwdata_i(bus_pwdata)
);

/* verif/boot_mem_sys_tb.sv */
// Boot subsystem testbench
`timescale 1ns/100ps

module boot_mem_sys_tb import boot_pkg::*;
();

   localparam int          CLK_PERIOD   = 10;
   localparam int          RESET_CYCLES = 16;
   localparam int          SETTLE       = 1;
   localparam logic [31:0] SEED         = 32'hcb4d_59dd;
   localparam int          NBF_WORDS    = 16;
   localparam int          NBF_BASE     = 128;
   localparam int          MEM_OPS      = 24;
   localparam int          BOOT_CYCLES  = 100;
   localparam int          BUS_TIMEOUT  = 200;
   localparam int          UPPER_W      = ADDR_W - MEM_AW - 3;
   localparam logic [7:0]  EXIT_CODE    = 8'h5a;
   localparam int TEST_CYCLES = RESET_CYCLES + BOOT_CYCLES + NBF_WORDS * 20 + MEM_OPS * 16 + 80;
   localparam int WATCHDOG_NS = TEST_CYCLES * 4 * CLK_PERIOD + 1000;

   logic              clk, reset;
   logic              nbf_valid, nbf_ready, nbf_last;
   logic [ADDR_W-1:0] nbf_addr, ext_paddr;
   logic [DATA_W-1:0] nbf_data, ext_pwdata, ext_prdata;
   logic              ext_psel, ext_penable, ext_pwrite, ext_pready, ext_pslverr;
   logic              freeze, finish;

   logic [DATA_W-1:0] mem_model [MEM_WORDS];
   logic [MEM_AW-1:0] written_q [$];
   int                checks, value_errors, other_errors;

   boot_mem_sys uut (
      .clk_i(clk), .reset_i(reset),
      .nbf_valid_i(nbf_valid), .nbf_ready_o(nbf_ready), .nbf_addr_i(nbf_addr),
      .nbf_data_i(nbf_data), .nbf_last_i(nbf_last),
      .ext_psel_i(ext_psel), .ext_penable_i(ext_penable), .ext_pwrite_i(ext_pwrite),
      .ext_paddr_i(ext_paddr), .ext_pwdata_i(ext_pwdata), .ext_prdata_o(ext_prdata),
      .ext_pready_o(ext_pready), .ext_pslverr_o(ext_pslverr),
      .freeze_o(freeze), .finish_o(finish)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [ADDR_W-1:0] mem_addr(logic [MEM_AW-1:0] index,
                                                  logic [UPPER_W-1:0] upper);
      bus_addr_u a;
      a           = '0;
      a.mem.index = index;
      a.mem.upper = upper;
      return a;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(logic [1:0] sel);
      bus_addr_u a;
      a             = '0;
      a.host.region = 1'b1;
      a.host.sel    = sel;
      return a;
   endfunction

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      checks++;
      if (act !== exp)
      begin
         value_errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         value_errors++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // One ext transfer; pready is sampled just after the falling edge
   task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
      int cycles;
      cycles = 0;
      @(negedge clk);
      ext_psel    = 1'b1;
      ext_penable = 1'b0;
      ext_pwrite  = wr;
      ext_paddr   = addr;
      ext_pwdata  = wdata;
      @(negedge clk);
      ext_penable = 1'b1;
      #SETTLE;
      while (!ext_pready && cycles < BUS_TIMEOUT)
      begin
         @(negedge clk);
         #SETTLE;
         cycles++;
      end
      if (!ext_pready)
      begin
         other_errors++;
         $display("Ext transfer to address %h never got pready", addr);
      end
      rdata = ext_prdata;
      err   = ext_pslverr;
      @(negedge clk);
      ext_psel    = 1'b0;
      ext_penable = 1'b0;
   endtask

   task automatic config_boot();
      int cycles;
      cycles = 0;
      check_flag("config_boot freeze after reset", 1'b1, freeze);
      check_flag("config_boot finish after reset", 1'b0, finish);
      check_flag("config_boot nbf_ready after reset", 1'b0, nbf_ready);
      while (freeze && cycles < BOOT_CYCLES)
      begin
         @(negedge clk);
         cycles++;
      end
      if (freeze)
      begin
         other_errors++;
         $display("Freeze was never released after reset");
      end
   endtask

   task automatic program_load();
      logic [MEM_AW-1:0] index;
      logic [DATA_W-1:0] rdata;
      logic              err;
      int                cycles;
      @(negedge clk);
      for (int i = 0; i < NBF_WORDS; i++)
      begin
         index            = MEM_AW'(NBF_BASE + i);
         nbf_valid        = 1'b1;
         nbf_addr         = mem_addr(index, '0);
         nbf_data         = $urandom();
         nbf_last         = (i == NBF_WORDS - 1);
         mem_model[index] = nbf_data;
         cycles           = 0;
         while (!nbf_ready && cycles < BUS_TIMEOUT)
         begin
            @(negedge clk);
            cycles++;
         end
         if (!nbf_ready)
         begin
            other_errors++;
            $display("Program word %0d was never accepted", i);
         end
         @(negedge clk);
         nbf_valid = 1'b0;
         nbf_last  = 1'b0;
         repeat ($urandom_range(0, 3)) @(negedge clk);
      end
      for (int i = 0; i < NBF_WORDS; i++)
      begin
         index = MEM_AW'(NBF_BASE + i);
         apb_transfer(1'b0, mem_addr(index, '0), '0, rdata, err);
         check_word("program_load readback", mem_model[index], rdata);
      end
   endtask

   // The ext port only owns the bus once the program is loaded
   task automatic core_id_read();
      logic [DATA_W-1:0] rdata;
      logic              err;
      apb_transfer(1'b0, reg_addr(HOST_REG_CORE_ID), '0, rdata, err);
      check_word("core_id read", DATA_W'(CORE_ID), rdata);
      check_flag("core_id pslverr", 1'b0, err);
   endtask

   task automatic memory_access();
      logic [MEM_AW-1:0] index;
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] rdata;
      logic              err;
      for (int i = 0; i < MEM_OPS; i++)
      begin
         index = MEM_AW'($urandom_range(0, 31));
         data  = $urandom();
         apb_transfer(1'b1, mem_addr(index, '0), data, rdata, err);
         check_flag("memory_access write pslverr", 1'b0, err);
         mem_model[index] = data;
         written_q.push_back(index);
      end
      for (int i = 0; i < MEM_OPS; i++)
      begin
         index = written_q[$urandom_range(0, written_q.size() - 1)];
         apb_transfer(1'b0, mem_addr(index, '0), '0, rdata, err);
         check_word("memory_access read", mem_model[index], rdata);
      end
   endtask

   task automatic unmapped_access();
      logic [MEM_AW-1:0]  index;
      logic [UPPER_W-1:0] upper;
      logic [DATA_W-1:0]  rdata;
      logic               err;
      index = written_q[0];
      upper = UPPER_W'($urandom_range(1, (1 << UPPER_W) - 1));
      apb_transfer(1'b1, mem_addr(index, upper), ~mem_model[index], rdata, err);
      check_flag("unmapped write pslverr", 1'b1, err);
      apb_transfer(1'b0, mem_addr(index, upper), '0, rdata, err);
      check_flag("unmapped read pslverr", 1'b1, err);
      apb_transfer(1'b0, mem_addr(index, '0), '0, rdata, err);
      check_word("unmapped memory unchanged", mem_model[index], rdata);
   endtask

   task automatic finish_flag();
      logic [DATA_W-1:0] rdata;
      logic              err;
      check_flag("finish low before write", 1'b0, finish);
      apb_transfer(1'b0, reg_addr(HOST_REG_FINISH), '0, rdata, err);
      check_word("finish register before write", 32'h0, rdata);
      apb_transfer(1'b1, reg_addr(HOST_REG_FINISH), DATA_W'(EXIT_CODE), rdata, err);
      check_flag("finish high after write", 1'b1, finish);
      apb_transfer(1'b0, reg_addr(HOST_REG_FINISH), '0, rdata, err);
      check_word("finish register after write", 32'h1, rdata);
      apb_transfer(1'b0, reg_addr(HOST_REG_SCRATCH), '0, rdata, err);
      check_word("finish exit code", DATA_W'(EXIT_CODE), rdata);
      repeat (8) @(negedge clk);
      check_flag("finish stays high", 1'b1, finish);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
      $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      reset       = 1'b1;
      nbf_valid   = 1'b0;
      nbf_addr    = '0;
      nbf_data    = '0;
      nbf_last    = 1'b0;
      ext_psel    = 1'b0;
      ext_penable = 1'b0;
      ext_pwrite  = 1'b0;
      ext_paddr   = '0;
      ext_pwdata  = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      config_boot();
      program_load();
      core_id_read();
      memory_access();
      unmapped_access();
      finish_flag();
      $display("Checks: %0d, value errors: %0d, other errors: %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* boot_mem_sys.f */
hdl/boot_pkg.sv
hdl/cfg_loader.sv
hdl/nbf_loader.sv
hdl/load_arbiter.sv
hdl/periph_decoder.sv
hdl/data_mem.sv
hdl/host_regs.sv
hdl/boot_mem_sys.sv
verif/boot_mem_sys_sva.sv
verif/boot_mem_sys_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := boot_mem_sys_tb
FILELIST  := boot_mem_sys.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)
